//--- cpu_pkg.sv
// ==========================================================
// widths, instruction field positions, opcode and ALU
// operation enums shared by the single-cycle CPU
// ==========================================================
`default_nettype none

package cpu_pkg;

   localparam int INSTR_WIDTH    = 16;
   localparam int PC_WIDTH       = 8;   // fixed by the branch target field
   localparam int REG_ADDR_WIDTH = 4;
   localparam int NUM_REGS       = 16;
   localparam int IMM_WIDTH      = 8;

   localparam int OPC_WIDTH    = 4;
   localparam int ALU_OP_WIDTH = 3;

   // instruction field positions
   localparam int CLASS_BIT   = 15;  // 0 selects an ALU instruction
   localparam int OPC_LSB     = 12;
   localparam int ALU_OP_LSB  = 12;
   localparam int RD_LSB      = 8;
   localparam int RA_LSB      = 4;
   localparam int RB_LSB      = 0;
   localparam int IMM_LSB     = 0;
   localparam int TGT_HI_LSB  = 8;   // target upper nibble
   localparam int TGT_LO_LSB  = 0;   // target lower nibble
   localparam int TGT_NIB_W   = 4;

   // top nibble of the non-ALU classes
   typedef enum logic [OPC_WIDTH-1:0] {
      OPC_JZ    = 4'b1000,
      OPC_JNZ   = 4'b1001,
      OPC_LOADI = 4'b1010,
      OPC_STOP  = 4'b1111
   } opcode_e;

   // codes 110 and 111 are left undefined, the ALU returns zero
   typedef enum logic [ALU_OP_WIDTH-1:0] {
      ALU_SLL  = 3'b000,
      ALU_SRL  = 3'b001,
      ALU_ADD  = 3'b010,
      ALU_SUB  = 3'b011,
      ALU_AND  = 3'b100,
      ALU_XNOR = 3'b101
   } alu_op_e;

endpackage

`default_nettype wire

//--- program_counter.sv
// ==========================================================
// program counter with increment, branch load and stop hold
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module program_counter
   import cpu_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                branch_taken,
   input  logic [PC_WIDTH-1:0] branch_target,
   input  logic                stop,
   output logic [PC_WIDTH-1:0] pc
);

   logic [PC_WIDTH-1:0] pc_inc;
   logic [PC_WIDTH-1:0] pc_next;

   assign pc_inc = pc + 1'b1;  // wraps at 255

   // stop wins over branch, branch over increment
   always_comb begin
      if (stop) begin
         pc_next = pc;
      end else if (branch_taken) begin
         pc_next = branch_target;
      end else begin
         pc_next = pc_inc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= pc_next;
      end
   end

endmodule

`default_nettype wire

//--- instr_decoder.sv
// ==========================================================
// instruction decoder: field slicing and control strobes
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
   import cpu_pkg::*;
(
   input  logic [INSTR_WIDTH-1:0]    instr,
   output alu_op_e                   alu_op,
   output logic [REG_ADDR_WIDTH-1:0] rd_addr,
   output logic [REG_ADDR_WIDTH-1:0] ra_addr,
   output logic [REG_ADDR_WIDTH-1:0] rb_addr,
   output logic [IMM_WIDTH-1:0]      imm,
   output logic [PC_WIDTH-1:0]       branch_target,
   output logic                      wr_en,
   output logic                      imm_sel,
   output logic                      jz,
   output logic                      jnz,
   output logic                      stop
);

   opcode_e opcode;
   logic    is_alu;
   logic    is_loadi;

   // register and immediate fields
   assign rd_addr = instr[RD_LSB +: REG_ADDR_WIDTH];
   assign ra_addr = instr[RA_LSB +: REG_ADDR_WIDTH];
   assign rb_addr = instr[RB_LSB +: REG_ADDR_WIDTH];
   assign imm     = instr[IMM_LSB +: IMM_WIDTH];

   // target is split around the tested register field
   assign branch_target = {instr[TGT_HI_LSB +: TGT_NIB_W],
                           instr[TGT_LO_LSB +: TGT_NIB_W]};

   // 110 and 111 pass through unchanged
   assign alu_op = alu_op_e'(instr[ALU_OP_LSB +: ALU_OP_WIDTH]);

   assign opcode = opcode_e'(instr[OPC_LSB +: OPC_WIDTH]);
   assign is_alu = ~instr[CLASS_BIT];

   // other top nibbles with bit 15 set fall through as no-ops
   assign is_loadi = (opcode == OPC_LOADI);
   assign jz       = (opcode == OPC_JZ);
   assign jnz      = (opcode == OPC_JNZ);
   assign stop     = (opcode == OPC_STOP);

   assign wr_en   = is_alu | is_loadi;
   assign imm_sel = is_loadi;

endmodule

`default_nettype wire

//--- reg_file.sv
// ==========================================================
// 16-entry register file, two combinational read ports
// and one write port clocked on the rising edge
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module reg_file
   import cpu_pkg::*;
#(
   parameter int DATA_WIDTH = 32
) (
   input  logic                      clk,
   input  logic                      wr_en,
   input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
   input  logic [DATA_WIDTH-1:0]     rd_data,
   input  logic [REG_ADDR_WIDTH-1:0] ra_addr,
   input  logic [REG_ADDR_WIDTH-1:0] rb_addr,
   output logic [DATA_WIDTH-1:0]     ra_data,
   output logic [DATA_WIDTH-1:0]     rb_data
);

   logic [DATA_WIDTH-1:0] regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[rd_addr] <= rd_data;
      end
   end

   // reads see the old value until the edge
   assign ra_data = regs[ra_addr];
   assign rb_data = regs[rb_addr];

endmodule

`default_nettype wire

//--- alu.sv
// ==========================================================
// ALU: logical shifts, add/subtract, AND and XNOR
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module alu
   import cpu_pkg::*;
#(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   input  alu_op_e               op,
   output logic [DATA_WIDTH-1:0] result
);

   localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

   logic [SHAMT_WIDTH-1:0] shamt;
   logic                   sub;
   logic [DATA_WIDTH-1:0]  b_addend;
   logic [DATA_WIDTH-1:0]  sum;

   assign shamt = b[SHAMT_WIDTH-1:0];

   // one adder shared by add and sub, b inverted plus carry in
   assign sub      = (op == ALU_SUB);
   assign b_addend = sub ? ~b : b;
   assign sum      = a + b_addend + {{(DATA_WIDTH-1){1'b0}}, sub};

   always_comb begin
      case (op)
         ALU_SLL: begin
            result = a << shamt;
         end
         ALU_SRL: begin
            result = a >> shamt;
         end
         ALU_ADD, ALU_SUB: begin
            result = sum;  // wraps, no carry out
         end
         ALU_AND: begin
            result = a & b;
         end
         ALU_XNOR: begin
            result = ~(a ^ b);
         end
         default: begin
            result = '0;  // undefined codes
         end
      endcase
   end

endmodule

`default_nettype wire

//--- exec_unit.sv
// ==========================================================
// execute stage: ALU, immediate select and branch decision
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_unit
   import cpu_pkg::*;
#(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0] ra_data,
   input  logic [DATA_WIDTH-1:0] rb_data,
   input  alu_op_e               alu_op,
   input  logic [IMM_WIDTH-1:0]  imm,
   input  logic                  imm_sel,
   input  logic                  jz,
   input  logic                  jnz,
   output logic [DATA_WIDTH-1:0] wb_data,
   output logic                  branch_taken
);

   logic [DATA_WIDTH-1:0] alu_result;
   logic [DATA_WIDTH-1:0] imm_ext;
   logic                  ra_zero;

   alu #(
      .DATA_WIDTH (DATA_WIDTH)
   ) alu_i (
      .a      (ra_data),
      .b      (rb_data),
      .op     (alu_op),
      .result (alu_result)
   );

   assign imm_ext = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm};  // zero-extended
   assign wb_data = imm_sel ? imm_ext : alu_result;

   // branch tests operand a only
   assign ra_zero      = ~|ra_data;
   assign branch_taken = (jz & ra_zero) | (jnz & ~ra_zero);

endmodule

`default_nettype wire

//--- cpu_top.sv
// ==========================================================
// single-cycle CPU top: fetch, decode, execute and writeback
// stages, write port brought out for observation
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_top
   import cpu_pkg::*;
#(
   parameter int DATA_WIDTH = 32
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [INSTR_WIDTH-1:0]    instr,
   output logic [PC_WIDTH-1:0]       pc,
   output logic                      wb_en,
   output logic [REG_ADDR_WIDTH-1:0] wb_addr,
   output logic [DATA_WIDTH-1:0]     wb_data,
   output logic                      branch_taken,
   output logic                      stop
);

   alu_op_e                   alu_op;
   logic [REG_ADDR_WIDTH-1:0] ra_addr;
   logic [REG_ADDR_WIDTH-1:0] rb_addr;
   logic [IMM_WIDTH-1:0]      imm;
   logic [PC_WIDTH-1:0]       branch_target;
   logic                      imm_sel;
   logic                      jz;
   logic                      jnz;
   logic [DATA_WIDTH-1:0]     ra_data;
   logic [DATA_WIDTH-1:0]     rb_data;

   // fetch
   program_counter pc_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .stop          (stop),
      .pc            (pc)
   );

   instr_decoder dec_i (
      .instr         (instr),
      .alu_op        (alu_op),
      .rd_addr       (wb_addr),
      .ra_addr       (ra_addr),
      .rb_addr       (rb_addr),
      .imm           (imm),
      .branch_target (branch_target),
      .wr_en         (wb_en),
      .imm_sel       (imm_sel),
      .jz            (jz),
      .jnz           (jnz),
      .stop          (stop)
   );

   // write port closes the loop at the next edge
   reg_file #(
      .DATA_WIDTH (DATA_WIDTH)
   ) rf_i (
      .clk     (clk),
      .wr_en   (wb_en),
      .rd_addr (wb_addr),
      .rd_data (wb_data),
      .ra_addr (ra_addr),
      .rb_addr (rb_addr),
      .ra_data (ra_data),
      .rb_data (rb_data)
   );

   exec_unit #(
      .DATA_WIDTH (DATA_WIDTH)
   ) ex_i (
      .ra_data      (ra_data),
      .rb_data      (rb_data),
      .alu_op       (alu_op),
      .imm          (imm),
      .imm_sel      (imm_sel),
      .jz           (jz),
      .jnz          (jnz),
      .wb_data      (wb_data),
      .branch_taken (branch_taken)
   );

endmodule

`default_nettype wire

//--- tb_cpu_top.sv
// ==========================================================
// testbench for cpu_top: program memory, reference model
// and per-cycle checks of pc and the writeback port
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
   import cpu_pkg::*;
();

   localparam int DATA_WIDTH = 32;
   localparam int SHW        = $clog2(DATA_WIDTH);
   localparam int MAX_CYCLES = 2000;
   localparam logic [INSTR_WIDTH-1:0] NOP = 16'hb000;  // unused top nibble

   logic                      clk;
   logic                      rst_n;
   logic [INSTR_WIDTH-1:0]    instr;
   logic [PC_WIDTH-1:0]       pc;
   logic                      wb_en;
   logic [REG_ADDR_WIDTH-1:0] wb_addr;
   logic [DATA_WIDTH-1:0]     wb_data;
   logic                      branch_taken;
   logic                      stop;

   logic [INSTR_WIDTH-1:0] prog_mem [256];
   logic [DATA_WIDTH-1:0]  shadow [NUM_REGS];
   logic [PC_WIDTH-1:0]    exp_pc;
   int unsigned            load_ptr;
   int unsigned            n_checks;
   int unsigned            n_errors;

   cpu_top #(
      .DATA_WIDTH (DATA_WIDTH)
   ) dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr        (instr),
      .pc           (pc),
      .wb_en        (wb_en),
      .wb_addr      (wb_addr),
      .wb_data      (wb_data),
      .branch_taken (branch_taken),
      .stop         (stop)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // instruction memory read, updated on the falling edge
   always @(negedge clk) begin
      instr <= $isunknown(pc) ? NOP : prog_mem[pc];
   end

   task automatic report_value(input string name, input logic [DATA_WIDTH-1:0] expv,
                               input logic [DATA_WIDTH-1:0] actv);
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expv, actv);
      n_errors++;
   endtask

   function automatic logic [DATA_WIDTH-1:0] alu_model(input logic [2:0] op,
         input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
      case (op)
         ALU_SLL:  return a << b[SHW-1:0];
         ALU_SRL:  return a >> b[SHW-1:0];
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_XNOR: return ~(a ^ b);
         default:  return '0;
      endcase
   endfunction

   task automatic emit(input logic [INSTR_WIDTH-1:0] word);
      prog_mem[load_ptr[PC_WIDTH-1:0]] = word;
      load_ptr++;
   endtask

   function automatic logic [INSTR_WIDTH-1:0] enc_alu(input logic [2:0] op,
         input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb);
      return {1'b0, op, rd, ra, rb};
   endfunction

   function automatic logic [INSTR_WIDTH-1:0] enc_loadi(input logic [3:0] rd,
         input logic [7:0] imm);
      return {OPC_LOADI, rd, imm};
   endfunction

   function automatic logic [INSTR_WIDTH-1:0] enc_branch(input opcode_e opc,
         input logic [3:0] rt, input logic [7:0] target);
      return {opc, target[7:4], rt, target[3:0]};
   endfunction

   // reference model, checked against the DUT at every rising edge
   always @(posedge clk) begin
      logic [3:0]            opc;
      logic [DATA_WIDTH-1:0] ra_val;
      logic [DATA_WIDTH-1:0] exp_data;
      logic                  exp_wr;
      logic                  exp_taken;
      logic                  exp_stop;
      if (!rst_n) begin
         exp_pc = '0;
      end else begin
         opc       = instr[15:12];
         ra_val    = shadow[instr[7:4]];
         exp_wr    = !instr[15] || opc == OPC_LOADI;
         exp_data  = instr[15] ? {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, instr[7:0]}
                               : alu_model(instr[14:12], ra_val, shadow[instr[3:0]]);
         exp_taken = (opc == OPC_JZ && ra_val == 0) || (opc == OPC_JNZ && ra_val != 0);
         exp_stop  = (opc == OPC_STOP);
         n_checks++;
         assert (pc == exp_pc) else report_value("pc", 32'(exp_pc), 32'(pc));
         assert (wb_en == exp_wr) else report_value("wb_en", 32'(exp_wr), 32'(wb_en));
         assert (branch_taken == exp_taken)
            else report_value("branch_taken", 32'(exp_taken), 32'(branch_taken));
         assert (stop == exp_stop) else report_value("stop", 32'(exp_stop), 32'(stop));
         if (exp_wr) begin
            assert (wb_addr == instr[11:8])
               else report_value("wb_addr", 32'(instr[11:8]), 32'(wb_addr));
            assert (wb_data == exp_data) else report_value("wb_data", exp_data, wb_data);
            shadow[instr[11:8]] = exp_data;
         end
         if (!exp_stop) begin
            exp_pc = exp_taken ? {instr[11:8], instr[3:0]} : exp_pc + 1'b1;
         end
      end
   end

   initial begin
      logic [3:0]  rd;
      logic [3:0]  rz;
      logic [3:0]  rn;
      int unsigned cycles;
      void'($urandom(75));
      rst_n    = 1'b0;
      instr    = NOP;
      load_ptr = 0;
      n_checks = 0;
      n_errors = 0;
      for (int a = 0; a < 256; a++) begin
         prog_mem[a] = {4'hb + 4'(a & 3), 8'(a), 4'h0};  // no-ops B..E
      end
      for (int r = 0; r < NUM_REGS; r++) begin
         emit(enc_loadi(4'(r), 8'($urandom)));
      end
      repeat (4) emit(enc_loadi(4'($urandom), 8'($urandom)));
      // every ALU code, then read the destination back
      for (int op = 0; op < 8; op++) begin
         rd = 4'($urandom);
         emit(enc_alu(3'(op), rd, 4'($urandom), 4'($urandom)));
         emit(enc_alu(ALU_AND, 4'($urandom), rd, rd));
      end
      rz = 4'($urandom);
      rn = rz + 4'd1;
      emit(enc_alu(ALU_SUB, rz, rn, rn));          // rz becomes zero
      emit(enc_loadi(rn, 8'($urandom) | 8'h01));
      emit(enc_branch(OPC_JZ, rn, 8'(load_ptr + 5)));
      emit(enc_branch(OPC_JNZ, rz, 8'(load_ptr + 5)));
      emit(enc_branch(OPC_JZ, rz, 8'(load_ptr + 3)));   // skips two words
      load_ptr += 2;
      emit(enc_branch(OPC_JNZ, rn, 8'hf8));        // runs out to the wrap

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n <= 1'b1;
      cycles = 0;
      while (stop !== 1'b1 && cycles < MAX_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (pc == 8'hff) begin
            prog_mem[0] = {OPC_STOP, 12'h000};  // stop after the wrap
         end
      end
      if (stop !== 1'b1) begin
         $display("timeout: the program never reached its stop instruction");
         n_errors++;
      end
      repeat (4) @(negedge clk);  // pc must hold while stopped
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
cpu_pkg.sv
program_counter.sv
instr_decoder.sv
reg_file.sv
alu.sv
exec_unit.sv
cpu_top.sv
tb_cpu_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cpu_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED
SOURCES   := $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
